// ==== Bender.yml ====
package:
  name: frame_fill

sources:
  # package first, then leaf blocks, then the top level
  - hdl/frame_fill_pkg.sv
  - hdl/fill_dispatch.sv
  - hdl/frame_filler.sv
  - hdl/burst_arbiter.sv
  - hdl/frame_fill_top.sv
  - target: simulation
    files:
      - bench/frame_fill_tb.sv

// ==== bench/frame_fill_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fill_tb;

  localparam int num_engines = 4;
  localparam int h_pixels = 32;
  localparam int v_lines = 4;
  localparam int num_cmds = 12;
  localparam int col_groups = h_pixels / 8;
  localparam int bursts_per_frame = col_groups * v_lines;
  // 12 frames x 32 beats, doubled for back-pressure, plus margin
  localparam int cycle_limit = 2000;

  logic                                clk;
  logic                                rst_n;
  logic                                cmd_valid;
  frame_fill_pkg::fill_cmd_t           cmd;
  logic                                cmd_ready;
  logic                                af_full;
  logic                                wdf_full;
  logic [frame_fill_pkg::addr_w-1:0]   af_addr_din;
  logic                                af_wr_en;
  logic [frame_fill_pkg::data_w-1:0]   wdf_din;
  logic                                wdf_wr_en;
  logic [frame_fill_pkg::mask_w-1:0]   wdf_mask_din;

  // scoreboard indexed by frame select
  logic [frame_fill_pkg::color_w-1:0]  color_tab [64];
  bit                                  issued [64];
  int                                  burst_cnt [64];
  bit [bursts_per_frame-1:0]           covered [64];
  logic [5:0]                          cur_sel;
  int                                  burst_open;
  int                                  in_flight;
  int                                  frames_done;
  int                                  af_count;
  int                                  wdf_count;
  int                                  errors;
  int                                  cycles;
  bit                                  started;

  frame_fill_top #(
    .num_engines(num_engines),
    .h_pixels   (h_pixels),
    .v_lines    (v_lines)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .af_full     (af_full),
    .wdf_full    (wdf_full),
    .af_addr_din (af_addr_din),
    .af_wr_en    (af_wr_en),
    .wdf_din     (wdf_din),
    .wdf_wr_en   (wdf_wr_en),
    .wdf_mask_din(wdf_mask_din)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic note_mismatch(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
    errors++;
    $display("error %s: expected %0h, actual %0h", name, exp, act);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("failure: %s", what);
  endtask

  // four copies of the colour each zero-extended to 32 bits
  function automatic logic [127:0] fill_word(input logic [23:0] c);
    return {4{8'h00, c}};
  endfunction

  // distinct frame selects since 7 is coprime with 64
  function automatic logic [5:0] sel_for_cmd(input int i);
    return 6'(7 * i + 5);
  endfunction

  task automatic send_cmd(input frame_fill_pkg::fill_cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    while (!cmd_ready) @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // random FIFO-full model with each flag high about a quarter of the time
  task automatic drive_full_flags();
    forever begin
      @(negedge clk);
      af_full  = ($urandom_range(3) == 0);
      wdf_full = ($urandom_range(3) == 0);
    end
  endtask

  task automatic close_run(input bit hung);
    $display("summary: %0d errors, %0d af writes, %0d wdf writes, %0d of %0d frames done",
             errors, af_count, wdf_count, frames_done, num_cmds);
    if (errors == 0 && !hung) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    int row;
    int grp;
    if (rst_n) begin
      if (cmd_valid && cmd_ready) begin
        started = 1'b1;
        in_flight++;
      end
      if (af_wr_en) begin
        cur_sel = af_addr_din[24:19];
        row = int'(af_addr_din[18:9]);
        grp = int'(af_addr_din[8:2]);
        assert ({af_addr_din[30:25], af_addr_din[1:0]} == '0)
          else note_mismatch("addr_pad", '0, {af_addr_din[30:25], af_addr_din[1:0]});
        assert (issued[cur_sel])
          else note_failure("address names a frame that was never issued");
        assert (burst_open == 0) else note_mismatch("burst_shape", 0, burst_open);
        if (row < v_lines && grp < col_groups) begin
          assert (!covered[cur_sel][row * col_groups + grp])
            else note_failure("the same row and column group was written twice");
          covered[cur_sel][row * col_groups + grp] = 1'b1;
        end else begin
          note_failure("address lies outside the frame");
        end
        burst_cnt[cur_sel]++;
        af_count++;
        burst_open = 1;
      end else if (wdf_wr_en) begin
        assert (burst_open == 1) else note_mismatch("burst_shape", 1, burst_open);
        burst_open = 0;
        // last burst of the frame frees its engine on this edge
        if (burst_cnt[cur_sel] == bursts_per_frame) begin
          frames_done++;
          in_flight--;
        end
      end
      if (wdf_wr_en) begin
        assert (wdf_din == fill_word(color_tab[cur_sel]))
          else note_mismatch("data", fill_word(color_tab[cur_sel]), wdf_din);
        wdf_count++;
      end
    end
  end

  a_reset_state: assert property (
    @(posedge clk) $rose(rst_n) |-> cmd_ready && !af_wr_en && !wdf_wr_en
  ) else note_failure("outputs not in their reset state after reset");

  a_quiet_before_cmd: assert property (
    @(posedge clk) disable iff (!rst_n) !started |-> !af_wr_en && !wdf_wr_en
  ) else note_failure("write enable raised before the first command");

  a_mask_zero: assert property (
    @(posedge clk) disable iff (!rst_n) wdf_wr_en |-> wdf_mask_din == '0
  ) else note_mismatch("mask", '0, $sampled(wdf_mask_din));

  a_back_pressure: assert property (
    @(posedge clk) disable iff (!rst_n) (af_full || wdf_full) |-> !af_wr_en && !wdf_wr_en
  ) else note_failure("write enable raised while a FIFO was full");

  // ready exactly when fewer than all engines hold a frame
  a_dispatch_limit: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_ready == (in_flight < num_engines)
  ) else note_mismatch("dispatch_limit", $sampled(in_flight < num_engines), $sampled(cmd_ready));

  initial begin
    frame_fill_pkg::fill_cmd_t c;
    void'($urandom(32'hce59_8eb4));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    af_full   = 1'b0;
    wdf_full  = 1'b0;
    fork
      drive_full_flags();
    join_none
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_cmds; i++) begin
      c.color      = 24'($urandom);
      c.frame_base = {4'($urandom), sel_for_cmd(i), 22'($urandom)};
      color_tab[sel_for_cmd(i)] = c.color;
      issued[sel_for_cmd(i)]    = 1'b1;
      send_cmd(c);
    end
    while (frames_done < num_cmds) @(negedge clk);
    repeat (4) @(negedge clk);
    for (int i = 0; i < num_cmds; i++) begin
      assert (burst_cnt[sel_for_cmd(i)] == bursts_per_frame)
        else note_mismatch("burst_count", bursts_per_frame, burst_cnt[sel_for_cmd(i)]);
      assert (&covered[sel_for_cmd(i)])
        else note_mismatch("coverage", {bursts_per_frame{1'b1}}, covered[sel_for_cmd(i)]);
    end
    assert (wdf_count == 2 * af_count) else note_mismatch("beat_ratio", 2 * af_count, wdf_count);
    close_run(1'b0);
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run hung after %0d cycles with %0d of %0d frames done",
             cycles, frames_done, num_cmds);
    close_run(1'b1);
  end

endmodule

`default_nettype wire

// ==== hdl/burst_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_arbiter #(
  parameter int num_engines = 4
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [num_engines-1:0] beat_valid,
  input  frame_fill_pkg::burst_beat_t beat [num_engines],
  output logic [num_engines-1:0]      beat_ready,
  input  wire logic                   af_full,
  input  wire logic                   wdf_full,
  output logic [frame_fill_pkg::addr_w-1:0] af_addr_din,
  output logic                        af_wr_en,
  output logic [frame_fill_pkg::data_w-1:0] wdf_din,
  output logic                        wdf_wr_en,
  output logic [frame_fill_pkg::mask_w-1:0] wdf_mask_din
);

  localparam int idx_w = (num_engines > 1) ? $clog2(num_engines) : 1;

  logic [idx_w-1:0] rr_ptr;
  logic [idx_w-1:0] grant;
  logic             locked;
  logic [idx_w-1:0] sel;
  logic             can_write;
  logic             fire;

  assign can_write = !af_full && !wdf_full;

  // locked grant wins, else search from the round-robin pointer
  always_comb begin
    int idx;
    logic found;
    sel = grant;
    found = locked;
    for (int k = 0; k < num_engines; k++) begin
      idx = int'(rr_ptr) + k;
      if (idx >= num_engines) idx = idx - num_engines;
      if (!found && beat_valid[idx]) begin
        sel = idx_w'(idx);
        found = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_engines; i++) begin
      beat_ready[i] = can_write && (sel == idx_w'(i));
    end
  end

  assign fire = can_write && beat_valid[sel];

  assign af_addr_din  = beat[sel].addr;
  assign wdf_din      = beat[sel].data;
  assign af_wr_en     = fire && beat[sel].first;
  assign wdf_wr_en    = fire;
  // every byte written
  assign wdf_mask_din = '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_ptr <= '0;
      grant  <= '0;
      locked <= 1'b0;
    end else if (fire) begin
      if (beat[sel].first) begin
        grant  <= sel;
        locked <= 1'b1;
      end else begin
        locked <= 1'b0;
        rr_ptr <= (sel == idx_w'(num_engines - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  a_af_with_wdf: assert property (
    @(posedge clk) disable iff (!rst_n)
    af_wr_en |-> wdf_wr_en
  );

  a_grant_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    locked |=> $stable(grant)
  );

  // granted engine keeps its data beat up between the two writes
  a_second_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    locked |-> beat_valid[grant] && !beat[grant].first
  );

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (af_full || wdf_full) |-> !af_wr_en && !wdf_wr_en
  );

endmodule

`default_nettype wire

// ==== hdl/fill_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_dispatch #(
  parameter int num_engines = 4
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       cmd_valid,
  input  frame_fill_pkg::fill_cmd_t       cmd,
  output logic                            cmd_ready,
  input  wire logic [num_engines-1:0]     eng_idle,
  output logic      [num_engines-1:0]     eng_cmd_valid,
  output frame_fill_pkg::fill_cmd_t       eng_cmd
);

  // payload fans out to every engine and only one valid bit rises
  assign eng_cmd = cmd;

  // any idle engine can take the next command
  assign cmd_ready = |eng_idle;

  // lowest-numbered idle engine wins
  always_comb begin
    logic found;
    found = 1'b0;
    eng_cmd_valid = '0;
    for (int i = 0; i < num_engines; i++) begin
      if (eng_idle[i] && !found) begin
        eng_cmd_valid[i] = cmd_valid;
        found = 1'b1;
      end
    end
  end

  // a command never lands on two engines
  a_one_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(eng_cmd_valid)
  );

  // a busy engine never sees a command
  a_idle_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    (eng_cmd_valid & ~eng_idle) == '0
  );

endmodule

`default_nettype wire

// ==== hdl/frame_fill_pkg.sv ====
`default_nettype none

package frame_fill_pkg;

  // pixel and memory word geometry
  localparam int color_w = 24;
  localparam int data_w = 128;
  localparam int mask_w = 16;
  localparam int addr_w = 31;

  // 32-bit colour slots packed into one data word
  localparam int pixels_per_word = 4;

  // two data words per burst
  localparam int pixels_per_burst = 8;

  // one host fill request
  typedef struct packed {
    logic [color_w-1:0] color;
    logic [31:0]        frame_base;
  } fill_cmd_t;

  // one write-data beat, first beat also carries the address
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              first;
  } burst_beat_t;

  // engine FSM
  typedef enum logic [1:0] {
    fill_idle   = 2'd0,
    fill_first  = 2'd1,
    fill_second = 2'd2
  } fill_state_t;

endpackage

`default_nettype wire

// ==== hdl/frame_fill_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fill_top #(
  parameter int num_engines = 4,
  parameter int h_pixels    = 800,
  parameter int v_lines     = 600
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         cmd_valid,
  input  frame_fill_pkg::fill_cmd_t         cmd,
  output logic                              cmd_ready,
  input  wire logic                         af_full,
  input  wire logic                         wdf_full,
  output logic [frame_fill_pkg::addr_w-1:0] af_addr_din,
  output logic                              af_wr_en,
  output logic [frame_fill_pkg::data_w-1:0] wdf_din,
  output logic                              wdf_wr_en,
  output logic [frame_fill_pkg::mask_w-1:0] wdf_mask_din
);

  logic [num_engines-1:0]      eng_idle;
  logic [num_engines-1:0]      eng_cmd_valid;
  frame_fill_pkg::fill_cmd_t   eng_cmd;
  logic [num_engines-1:0]      beat_valid;
  logic [num_engines-1:0]      beat_ready;
  frame_fill_pkg::burst_beat_t beat [num_engines];

  fill_dispatch #(
    .num_engines(num_engines)
  ) dispatch_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_ready    (cmd_ready),
    .eng_idle     (eng_idle),
    .eng_cmd_valid(eng_cmd_valid),
    .eng_cmd      (eng_cmd)
  );

  for (genvar i = 0; i < num_engines; i++) begin : g_engine
    frame_filler #(
      .h_pixels(h_pixels),
      .v_lines (v_lines)
    ) filler_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (eng_cmd_valid[i]),
      .cmd       (eng_cmd),
      .idle      (eng_idle[i]),
      .beat_valid(beat_valid[i]),
      .beat      (beat[i]),
      .beat_ready(beat_ready[i])
    );
  end

  burst_arbiter #(
    .num_engines(num_engines)
  ) arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .beat_ready  (beat_ready),
    .af_full     (af_full),
    .wdf_full    (wdf_full),
    .af_addr_din (af_addr_din),
    .af_wr_en    (af_wr_en),
    .wdf_din     (wdf_din),
    .wdf_wr_en   (wdf_wr_en),
    .wdf_mask_din(wdf_mask_din)
  );

endmodule

`default_nettype wire

// ==== hdl/frame_filler.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_filler #(
  parameter int h_pixels = 800,
  parameter int v_lines  = 600
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   cmd_valid,
  input  frame_fill_pkg::fill_cmd_t   cmd,
  output logic                        idle,
  output logic                        beat_valid,
  output frame_fill_pkg::burst_beat_t beat,
  input  wire logic                   beat_ready
);

  localparam int col_w = 10;
  localparam int row_w = 10;
  localparam int word_w = frame_fill_pkg::data_w / frame_fill_pkg::pixels_per_word;
  localparam logic [col_w-1:0] last_col = col_w'(h_pixels - frame_fill_pkg::pixels_per_burst);
  localparam logic [row_w-1:0] last_row = row_w'(v_lines - 1);

  frame_fill_pkg::fill_state_t state;

  logic [frame_fill_pkg::color_w-1:0] color;
  logic [5:0]                         frame_sel;
  logic [col_w-1:0]                   col;
  logic [row_w-1:0]                   row;
  logic [word_w-1:0]                  color_word;
  logic                               beat_fire;
  logic                               last_burst;

  assign idle       = (state == frame_fill_pkg::fill_idle);
  assign beat_valid = !idle;
  assign beat_fire  = beat_valid && beat_ready;
  assign last_burst = (col == last_col) && (row == last_row);

  // colour zero-extended into each 32-bit slot
  assign color_word = {{(word_w - frame_fill_pkg::color_w){1'b0}}, color};

  assign beat.addr  = {6'b0, frame_sel, row, col[col_w-1:3], 2'b0};
  assign beat.data  = {frame_fill_pkg::pixels_per_word{color_word}};
  assign beat.first = (state == frame_fill_pkg::fill_first);

  // command payload, held for the whole frame
  always_ff @(posedge clk) begin
    if (idle && cmd_valid) begin
      color     <= cmd.color;
      frame_sel <= cmd.frame_base[27:22];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= frame_fill_pkg::fill_idle;
      col   <= '0;
      row   <= '0;
    end else begin
      case (state)
        frame_fill_pkg::fill_idle: begin
          if (cmd_valid) begin
            state <= frame_fill_pkg::fill_first;
            col   <= '0;
            row   <= '0;
          end
        end
        frame_fill_pkg::fill_first: begin
          if (beat_fire) begin
            state <= frame_fill_pkg::fill_second;
          end
        end
        frame_fill_pkg::fill_second: begin
          if (beat_fire) begin
            if (last_burst) begin
              state <= frame_fill_pkg::fill_idle;
            end else begin
              state <= frame_fill_pkg::fill_first;
              // wrap to the next row at the right edge
              if (col == last_col) begin
                col <= '0;
                row <= row + 1'b1;
              end else begin
                col <= col + col_w'(frame_fill_pkg::pixels_per_burst);
              end
            end
          end
        end
        default: state <= frame_fill_pkg::fill_idle;
      endcase
    end
  end

  // a burst is never abandoned after its address beat
  a_no_abort: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == frame_fill_pkg::fill_first |=> state != frame_fill_pkg::fill_idle
  );

  // stalled beat holds still
  a_beat_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/frame_fill_pkg.sv
hdl/fill_dispatch.sv
hdl/frame_filler.sv
hdl/burst_arbiter.sv
hdl/frame_fill_top.sv
bench/frame_fill_tb.sv
